// File: rtl/mmu_csr_pkg.sv
// opcode encodings are fixed here; mem_op bit 1 marks a real load or store access
package mmu_csr_pkg;

   typedef logic [1:0] plv_t;  // 0 kernel, 3 user
   typedef logic [1:0] mat_t;

   // data-port access kind
   typedef enum logic [1:0] {
      mem_none  = 2'b00,
      mem_load  = 2'b10,
      mem_store = 2'b11
   } mem_op_e;

   // tlb write request, one per cycle at most
   typedef enum logic [1:0] {
      tlb_op_none = 2'b00,
      tlb_op_wr   = 2'b01,
      tlb_op_fill = 2'b10
   } tlb_op_e;

endpackage

// File: rtl/mmu_dmw_check.sv
// windows match on va[31:29] only; plv 1 and 2 never hit, and the mat field is not decoded
`timescale 1ns/1ps
`include "mmu_params.svh"

module mmu_dmw_check (
   input  logic [`MMU_VA_W-1:0] va_i,
   input  mmu_csr_pkg::plv_t    plv_i,
   input  logic [31:0]          dmw0_i,
   input  logic [31:0]          dmw1_i,
   output logic                 hit_o,
   output logic [`MMU_VA_W-1:0] pa_o
);

   logic hit0;
   logic hit1;

   // privilege gate plus segment compare for one window word
   function automatic logic win_hit(input logic [31:0] dmw, input mmu_csr_pkg::plv_t plv,
                                    input logic [2:0] seg);
      return ((dmw[`MMU_DMW_PLV0] && plv == 2'd0) ||
              (dmw[`MMU_DMW_PLV3] && plv == 2'd3)) &&
             (seg == dmw[`MMU_DMW_VSEG]);
   endfunction

   assign hit0  = win_hit(dmw0_i, plv_i, va_i[31:29]);
   assign hit1  = win_hit(dmw1_i, plv_i, va_i[31:29]);
   assign hit_o = hit0 | hit1;

   assign pa_o = hit0 ? {dmw0_i[`MMU_DMW_PSEG], va_i[28:0]}   // dmw0 first
                      : {dmw1_i[`MMU_DMW_PSEG], va_i[28:0]};

endmodule

// File: rtl/mmu_fetch_xlate.sv
// fully combinational; pa_o is don't-care whenever exc_o is not exc_none
`timescale 1ns/1ps
`include "mmu_params.svh"

module mmu_fetch_xlate (
   input  logic [`MMU_VA_W-1:0]   va_i,
   input  logic                   csr_da_i,
   input  mmu_csr_pkg::plv_t      csr_plv_i,
   input  logic [31:0]            csr_dmw0_i,
   input  logic [31:0]            csr_dmw1_i,
   input  logic                   tlb_found_i,
   input  logic [`MMU_PPN_W-1:0]  tlb_ppn_i,
   input  logic [`MMU_PS_W-1:0]   tlb_ps_i,
   input  mmu_csr_pkg::plv_t      tlb_plv_i,
   input  logic                   tlb_v_i,
   output logic [`MMU_VPPN_W-1:0] s_vppn_o,
   output logic [1:0]             s_odd_o,
   output logic [`MMU_VA_W-1:0]   pa_o,
   output mmu_tlb_pkg::exc_e      exc_o
);

   logic                 dmw_hit;
   logic [`MMU_VA_W-1:0] dmw_pa;
   logic [`MMU_VA_W-1:0] tlb_pa;

   mmu_dmw_check u_dmw (
      .va_i   (va_i),
      .plv_i  (csr_plv_i),
      .dmw0_i (csr_dmw0_i),
      .dmw1_i (csr_dmw1_i),
      .hit_o  (dmw_hit),
      .pa_o   (dmw_pa)
   );

   assign s_vppn_o = va_i[31:13];
   assign s_odd_o  = {va_i[21], va_i[12]};

   assign tlb_pa = (tlb_ps_i == `MMU_PS_4M) ? {tlb_ppn_i[19:9], va_i[20:0]}
                                            : {tlb_ppn_i, va_i[11:0]};
   assign pa_o   = csr_da_i ? va_i : (dmw_hit ? dmw_pa : tlb_pa);

   always_comb begin
      exc_o = mmu_tlb_pkg::exc_none;
      if (!csr_da_i && !dmw_hit) begin   // mapped, no window
         if (csr_plv_i == 2'd3 && va_i[31]) exc_o = mmu_tlb_pkg::exc_ade;
         else if (!tlb_found_i)             exc_o = mmu_tlb_pkg::exc_tlbr;
         else if (!tlb_v_i)                 exc_o = mmu_tlb_pkg::exc_pif;
         else if (csr_plv_i > tlb_plv_i)    exc_o = mmu_tlb_pkg::exc_ppi;
      end
   end

endmodule

// File: rtl/mmu_ls_xlate.sv
// fully combinational; mem_none never faults, pa_o is don't-care whenever exc_o is not exc_none
`timescale 1ns/1ps
`include "mmu_params.svh"

module mmu_ls_xlate (
   input  logic [`MMU_VA_W-1:0]   va_i,
   input  mmu_csr_pkg::mem_op_e   mem_op_i,
   input  logic                   csr_da_i,
   input  mmu_csr_pkg::plv_t      csr_plv_i,
   input  logic [31:0]            csr_dmw0_i,
   input  logic [31:0]            csr_dmw1_i,
   input  logic                   tlb_found_i,
   input  logic [`MMU_PPN_W-1:0]  tlb_ppn_i,
   input  logic [`MMU_PS_W-1:0]   tlb_ps_i,
   input  mmu_csr_pkg::plv_t      tlb_plv_i,
   input  logic                   tlb_d_i,
   input  logic                   tlb_v_i,
   output logic [`MMU_VPPN_W-1:0] s_vppn_o,
   output logic [1:0]             s_odd_o,
   output logic [`MMU_VA_W-1:0]   pa_o,
   output mmu_tlb_pkg::exc_e      exc_o
);

   logic                 dmw_hit;
   logic [`MMU_VA_W-1:0] dmw_pa;
   logic [`MMU_VA_W-1:0] tlb_pa;
   logic                 is_store;
   logic                 mapped;

   mmu_dmw_check u_dmw (
      .va_i   (va_i),
      .plv_i  (csr_plv_i),
      .dmw0_i (csr_dmw0_i),
      .dmw1_i (csr_dmw1_i),
      .hit_o  (dmw_hit),
      .pa_o   (dmw_pa)
   );

   assign s_vppn_o = va_i[31:13];
   assign s_odd_o  = {va_i[21], va_i[12]};

   assign tlb_pa = (tlb_ps_i == `MMU_PS_4M) ? {tlb_ppn_i[19:9], va_i[20:0]}
                                            : {tlb_ppn_i, va_i[11:0]};
   assign pa_o   = csr_da_i ? va_i : (dmw_hit ? dmw_pa : tlb_pa);

   assign is_store = (mem_op_i == mmu_csr_pkg::mem_store);
   assign mapped   = !csr_da_i && !dmw_hit && (mem_op_i != mmu_csr_pkg::mem_none);

   // first failing check wins
   always_comb begin
      exc_o = mmu_tlb_pkg::exc_none;
      if (mapped) begin
         if (csr_plv_i == 2'd3 && va_i[31]) begin
            exc_o = mmu_tlb_pkg::exc_ade;
         end else if (!tlb_found_i) begin
            exc_o = mmu_tlb_pkg::exc_tlbr;
         end else if (!tlb_v_i) begin
            exc_o = is_store ? mmu_tlb_pkg::exc_pis : mmu_tlb_pkg::exc_pil;
         end else if (csr_plv_i > tlb_plv_i) begin
            exc_o = mmu_tlb_pkg::exc_ppi;
         end else if (is_store && !tlb_d_i) begin
            exc_o = mmu_tlb_pkg::exc_pme;   // write to a clean page
         end
      end
   end

endmodule

// File: rtl/mmu_params.svh
// TLB index width follows MMU_TLB_NUM; any page-size code other than MMU_PS_4M is handled as 4 KB
`ifndef MMU_PARAMS_SVH
`define MMU_PARAMS_SVH

`define MMU_TLB_NUM 16
`define MMU_VA_W    32
`define MMU_VPPN_W  19  // va[31:13]
`define MMU_PPN_W   20
`define MMU_ASID_W  10
`define MMU_PS_W    6

// page-size codes as held in tlbidx.ps
`define MMU_PS_4K 6'd12
`define MMU_PS_4M 6'd21

// tlbidx
`define MMU_TLBIDX_INDEX 3:0
`define MMU_TLBIDX_PS    29:24
`define MMU_TLBIDX_NE    31

// tlbehi
`define MMU_TLBEHI_VPPN 31:13

// tlbelo0 and tlbelo1 share one layout
`define MMU_TLBELO_V   0
`define MMU_TLBELO_D   1
`define MMU_TLBELO_PLV 3:2
`define MMU_TLBELO_MAT 5:4
`define MMU_TLBELO_G   6
`define MMU_TLBELO_PPN 27:8

// dmw0 and dmw1
`define MMU_DMW_PLV0 0
`define MMU_DMW_PLV3 3
`define MMU_DMW_MAT  5:4
`define MMU_DMW_PSEG 27:25
`define MMU_DMW_VSEG 31:29

`endif

// File: rtl/mmu_tlb_array.sv
// writes land at the clock edge, searches are combinational; reset clears existence bits only
`timescale 1ns/1ps
`include "mmu_params.svh"

module mmu_tlb_array (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic [`MMU_VPPN_W-1:0]    s0_vppn_i,
   input  logic [1:0]                s0_odd_i,   // {va[21], va[12]}
   input  logic [`MMU_VPPN_W-1:0]    s1_vppn_i,
   input  logic [1:0]                s1_odd_i,
   input  logic [`MMU_ASID_W-1:0]    asid_i,
   input  logic                      we_i,
   input  mmu_tlb_pkg::tlb_idx_t     w_index_i,
   input  logic                      w_e_i,
   input  logic [`MMU_VPPN_W-1:0]    w_vppn_i,
   input  logic [`MMU_PS_W-1:0]      w_ps_i,
   input  logic [`MMU_ASID_W-1:0]    w_asid_i,
   input  logic                      w_g_i,
   input  logic [`MMU_PPN_W-1:0]     w_ppn0_i,
   input  mmu_csr_pkg::plv_t         w_plv0_i,
   input  mmu_csr_pkg::mat_t         w_mat0_i,
   input  logic                      w_d0_i,
   input  logic                      w_v0_i,
   input  logic [`MMU_PPN_W-1:0]     w_ppn1_i,
   input  mmu_csr_pkg::plv_t         w_plv1_i,
   input  mmu_csr_pkg::mat_t         w_mat1_i,
   input  logic                      w_d1_i,
   input  logic                      w_v1_i,
   output logic                      s0_found_o,
   output logic [`MMU_PPN_W-1:0]     s0_ppn_o,
   output logic [`MMU_PS_W-1:0]      s0_ps_o,
   output mmu_csr_pkg::plv_t         s0_plv_o,
   output logic                      s0_d_o,
   output logic                      s0_v_o,
   output logic                      s1_found_o,
   output logic [`MMU_PPN_W-1:0]     s1_ppn_o,
   output logic [`MMU_PS_W-1:0]      s1_ps_o,
   output mmu_csr_pkg::plv_t         s1_plv_o,
   output logic                      s1_d_o,
   output logic                      s1_v_o
);

   localparam int NUM = `MMU_TLB_NUM;

   logic [NUM-1:0]          tlb_e;
   logic [`MMU_VPPN_W-1:0]  tlb_vppn [NUM];
   logic [`MMU_PS_W-1:0]    tlb_ps   [NUM];
   logic [`MMU_ASID_W-1:0]  tlb_asid [NUM];
   logic [NUM-1:0]          tlb_g;
   logic [`MMU_PPN_W-1:0]   tlb_ppn  [NUM][2];
   mmu_csr_pkg::plv_t       tlb_plv  [NUM][2];
   logic [1:0]              tlb_d    [NUM];
   logic [1:0]              tlb_v    [NUM];

   logic [NUM-1:0]          ent_4m;
   logic [NUM-1:0]          ent_live;   // exists and asid or global ok
   logic [NUM-1:0]          s0_match;
   logic [NUM-1:0]          s1_match;
   mmu_tlb_pkg::tlb_idx_t   s0_idx;
   mmu_tlb_pkg::tlb_idx_t   s1_idx;
   logic                    s0_half;
   logic                    s1_half;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         tlb_e <= '0;
      end else if (we_i) begin
         tlb_e[w_index_i] <= w_e_i;
      end
   end

   always_ff @(posedge clk) begin
      if (we_i) begin
         tlb_vppn[w_index_i]   <= w_vppn_i;
         tlb_ps[w_index_i]     <= w_ps_i;
         tlb_asid[w_index_i]   <= w_asid_i;
         tlb_g[w_index_i]      <= w_g_i;
         tlb_ppn[w_index_i][0] <= w_ppn0_i;
         tlb_plv[w_index_i][0] <= w_plv0_i;
         tlb_ppn[w_index_i][1] <= w_ppn1_i;
         tlb_plv[w_index_i][1] <= w_plv1_i;
         tlb_d[w_index_i]      <= {w_d1_i, w_d0_i};
         tlb_v[w_index_i]      <= {w_v1_i, w_v0_i};
      end
   end

   // 4 MB pages compare va[31:22] only
   function automatic logic vppn_match(input logic four_m, input logic [`MMU_VPPN_W-1:0] tag,
                                       input logic [`MMU_VPPN_W-1:0] vppn);
      return four_m ? tag[18:9] == vppn[18:9] : tag == vppn;
   endfunction

   function automatic mmu_tlb_pkg::tlb_idx_t first_hit(input logic [NUM-1:0] m);
      mmu_tlb_pkg::tlb_idx_t idx;
      idx = '0;
      for (int i = NUM - 1; i >= 0; i--) begin
         if (m[i]) idx = mmu_tlb_pkg::tlb_idx_t'(i);   // lowest index ends up last
      end
      return idx;
   endfunction

   for (genvar g = 0; g < NUM; g++) begin : g_match
      assign ent_4m[g]   = (tlb_ps[g] == `MMU_PS_4M);
      assign ent_live[g] = tlb_e[g] && (tlb_g[g] || tlb_asid[g] == asid_i);
      assign s0_match[g] = ent_live[g] && vppn_match(ent_4m[g], tlb_vppn[g], s0_vppn_i);
      assign s1_match[g] = ent_live[g] && vppn_match(ent_4m[g], tlb_vppn[g], s1_vppn_i);
   end

   assign s0_idx  = first_hit(s0_match);
   assign s0_half = ent_4m[s0_idx] ? s0_odd_i[1] : s0_odd_i[0];
   assign s1_idx  = first_hit(s1_match);
   assign s1_half = ent_4m[s1_idx] ? s1_odd_i[1] : s1_odd_i[0];

   assign s0_found_o = |s0_match;
   assign s0_ppn_o   = tlb_ppn[s0_idx][s0_half];
   assign s0_ps_o    = tlb_ps[s0_idx];
   assign s0_plv_o   = tlb_plv[s0_idx][s0_half];
   assign s0_d_o     = tlb_d[s0_idx][s0_half];
   assign s0_v_o     = tlb_v[s0_idx][s0_half];

   assign s1_found_o = |s1_match;
   assign s1_ppn_o   = tlb_ppn[s1_idx][s1_half];
   assign s1_ps_o    = tlb_ps[s1_idx];
   assign s1_plv_o   = tlb_plv[s1_idx][s1_half];
   assign s1_d_o     = tlb_d[s1_idx][s1_half];
   assign s1_v_o     = tlb_v[s1_idx][s1_half];

endmodule

// File: rtl/mmu_tlb_pkg.sv
// exc_ade stands for ADEF on the fetch port and ADEM on the data port
`include "mmu_params.svh"

package mmu_tlb_pkg;

   typedef logic [$clog2(`MMU_TLB_NUM)-1:0] tlb_idx_t;

   // one code per port, priority already resolved
   typedef enum logic [2:0] {
      exc_none = 3'd0,
      exc_ade  = 3'd1,
      exc_tlbr = 3'd2,
      exc_pif  = 3'd3,
      exc_pil  = 3'd4,
      exc_pis  = 3'd5,
      exc_ppi  = 3'd6,
      exc_pme  = 3'd7
   } exc_e;

endpackage

// File: rtl/mmu_tlb_write_ctrl.sv
// fill pointer moves only on TLBFILL and wraps at MMU_TLB_NUM; TLBWR leaves it alone
`timescale 1ns/1ps
`include "mmu_params.svh"

module mmu_tlb_write_ctrl (
   input  logic                   clk,
   input  logic                   rst_n,
   input  mmu_csr_pkg::tlb_op_e   tlb_op_i,
   input  logic [`MMU_ASID_W-1:0] csr_asid_i,
   input  logic [31:0]            csr_tlbidx_i,
   input  logic [31:0]            csr_tlbehi_i,
   input  logic [31:0]            csr_tlbelo0_i,
   input  logic [31:0]            csr_tlbelo1_i,
   output logic                   we_o,
   output mmu_tlb_pkg::tlb_idx_t  w_index_o,
   output logic                   w_e_o,
   output logic [`MMU_VPPN_W-1:0] w_vppn_o,
   output logic [`MMU_PS_W-1:0]   w_ps_o,
   output logic [`MMU_ASID_W-1:0] w_asid_o,
   output logic                   w_g_o,
   output logic [`MMU_PPN_W-1:0]  w_ppn0_o,
   output mmu_csr_pkg::plv_t      w_plv0_o,
   output mmu_csr_pkg::mat_t      w_mat0_o,
   output logic                   w_d0_o,
   output logic                   w_v0_o,
   output logic [`MMU_PPN_W-1:0]  w_ppn1_o,
   output mmu_csr_pkg::plv_t      w_plv1_o,
   output mmu_csr_pkg::mat_t      w_mat1_o,
   output logic                   w_d1_o,
   output logic                   w_v1_o
);

   mmu_tlb_pkg::tlb_idx_t fill_ptr;
   logic                  is_fill;

   assign is_fill = (tlb_op_i == mmu_csr_pkg::tlb_op_fill);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         fill_ptr <= '0;
      end else if (is_fill) begin
         fill_ptr <= fill_ptr + 1'b1;
      end
   end

   assign we_o      = is_fill || (tlb_op_i == mmu_csr_pkg::tlb_op_wr);
   assign w_index_o = is_fill ? fill_ptr : csr_tlbidx_i[`MMU_TLBIDX_INDEX];

   assign w_e_o    = ~csr_tlbidx_i[`MMU_TLBIDX_NE];   // ne set writes an empty slot
   assign w_ps_o   = csr_tlbidx_i[`MMU_TLBIDX_PS];
   assign w_vppn_o = csr_tlbehi_i[`MMU_TLBEHI_VPPN];
   assign w_asid_o = csr_asid_i;
   assign w_g_o    = csr_tlbelo0_i[`MMU_TLBELO_G] & csr_tlbelo1_i[`MMU_TLBELO_G];

   // even half
   assign w_ppn0_o = csr_tlbelo0_i[`MMU_TLBELO_PPN];
   assign w_plv0_o = csr_tlbelo0_i[`MMU_TLBELO_PLV];
   assign w_mat0_o = csr_tlbelo0_i[`MMU_TLBELO_MAT];
   assign w_d0_o   = csr_tlbelo0_i[`MMU_TLBELO_D];
   assign w_v0_o   = csr_tlbelo0_i[`MMU_TLBELO_V];

   // odd half
   assign w_ppn1_o = csr_tlbelo1_i[`MMU_TLBELO_PPN];
   assign w_plv1_o = csr_tlbelo1_i[`MMU_TLBELO_PLV];
   assign w_mat1_o = csr_tlbelo1_i[`MMU_TLBELO_MAT];
   assign w_d1_o   = csr_tlbelo1_i[`MMU_TLBELO_D];
   assign w_v1_o   = csr_tlbelo1_i[`MMU_TLBELO_V];

endmodule

// File: rtl/mmu_top.sv
// translation is same-cycle combinational; a TLB write in cycle N is visible from cycle N+1
`timescale 1ns/1ps
`include "mmu_params.svh"

module mmu_top (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic [`MMU_VA_W-1:0]   fetch_va_i,
   input  logic [`MMU_VA_W-1:0]   data_va_i,
   input  mmu_csr_pkg::mem_op_e   mem_op_i,
   input  mmu_csr_pkg::tlb_op_e   tlb_op_i,
   input  logic                   csr_da_i,
   input  mmu_csr_pkg::plv_t      csr_plv_i,
   input  logic [`MMU_ASID_W-1:0] csr_asid_i,
   input  logic [31:0]            csr_tlbidx_i,
   input  logic [31:0]            csr_tlbehi_i,
   input  logic [31:0]            csr_tlbelo0_i,
   input  logic [31:0]            csr_tlbelo1_i,
   input  logic [31:0]            csr_dmw0_i,
   input  logic [31:0]            csr_dmw1_i,
   output logic [`MMU_VA_W-1:0]   fetch_pa_o,
   output mmu_tlb_pkg::exc_e      fetch_exc_o,
   output logic [`MMU_VA_W-1:0]   data_pa_o,
   output mmu_tlb_pkg::exc_e      data_exc_o
);

   // search port 0 is fetch, port 1 is data
   logic [`MMU_VPPN_W-1:0] s0_vppn;
   logic [1:0]             s0_odd;
   logic                   s0_found;
   logic [`MMU_PPN_W-1:0]  s0_ppn;
   logic [`MMU_PS_W-1:0]   s0_ps;
   mmu_csr_pkg::plv_t      s0_plv;
   logic                   s0_v;
   logic [`MMU_VPPN_W-1:0] s1_vppn;
   logic [1:0]             s1_odd;
   logic                   s1_found;
   logic [`MMU_PPN_W-1:0]  s1_ppn;
   logic [`MMU_PS_W-1:0]   s1_ps;
   mmu_csr_pkg::plv_t      s1_plv;
   logic                   s1_d;
   logic                   s1_v;

   // write port
   logic                   we;
   mmu_tlb_pkg::tlb_idx_t  w_index;
   logic                   w_e;
   logic [`MMU_VPPN_W-1:0] w_vppn;
   logic [`MMU_PS_W-1:0]   w_ps;
   logic [`MMU_ASID_W-1:0] w_asid;
   logic                   w_g;
   logic [`MMU_PPN_W-1:0]  w_ppn0;
   mmu_csr_pkg::plv_t      w_plv0;
   mmu_csr_pkg::mat_t      w_mat0;
   logic                   w_d0;
   logic                   w_v0;
   logic [`MMU_PPN_W-1:0]  w_ppn1;
   mmu_csr_pkg::plv_t      w_plv1;
   mmu_csr_pkg::mat_t      w_mat1;
   logic                   w_d1;
   logic                   w_v1;

   mmu_fetch_xlate u_fetch (
      .va_i (fetch_va_i), .csr_da_i (csr_da_i), .csr_plv_i (csr_plv_i),
      .csr_dmw0_i (csr_dmw0_i), .csr_dmw1_i (csr_dmw1_i),
      .tlb_found_i (s0_found), .tlb_ppn_i (s0_ppn), .tlb_ps_i (s0_ps),
      .tlb_plv_i (s0_plv), .tlb_v_i (s0_v),
      .s_vppn_o (s0_vppn), .s_odd_o (s0_odd), .pa_o (fetch_pa_o), .exc_o (fetch_exc_o)
   );

   mmu_ls_xlate u_ls (
      .va_i (data_va_i), .mem_op_i (mem_op_i), .csr_da_i (csr_da_i), .csr_plv_i (csr_plv_i),
      .csr_dmw0_i (csr_dmw0_i), .csr_dmw1_i (csr_dmw1_i),
      .tlb_found_i (s1_found), .tlb_ppn_i (s1_ppn), .tlb_ps_i (s1_ps),
      .tlb_plv_i (s1_plv), .tlb_d_i (s1_d), .tlb_v_i (s1_v),
      .s_vppn_o (s1_vppn), .s_odd_o (s1_odd), .pa_o (data_pa_o), .exc_o (data_exc_o)
   );

   mmu_tlb_write_ctrl u_wctrl (
      .clk (clk), .rst_n (rst_n), .tlb_op_i (tlb_op_i), .csr_asid_i (csr_asid_i),
      .csr_tlbidx_i (csr_tlbidx_i), .csr_tlbehi_i (csr_tlbehi_i),
      .csr_tlbelo0_i (csr_tlbelo0_i), .csr_tlbelo1_i (csr_tlbelo1_i),
      .we_o (we), .w_index_o (w_index), .w_e_o (w_e), .w_vppn_o (w_vppn), .w_ps_o (w_ps),
      .w_asid_o (w_asid), .w_g_o (w_g),
      .w_ppn0_o (w_ppn0), .w_plv0_o (w_plv0), .w_mat0_o (w_mat0), .w_d0_o (w_d0), .w_v0_o (w_v0),
      .w_ppn1_o (w_ppn1), .w_plv1_o (w_plv1), .w_mat1_o (w_mat1), .w_d1_o (w_d1), .w_v1_o (w_v1)
   );

   mmu_tlb_array u_tlb (
      .clk (clk), .rst_n (rst_n),
      .s0_vppn_i (s0_vppn), .s0_odd_i (s0_odd), .s1_vppn_i (s1_vppn), .s1_odd_i (s1_odd),
      .asid_i (csr_asid_i),
      .we_i (we), .w_index_i (w_index), .w_e_i (w_e), .w_vppn_i (w_vppn), .w_ps_i (w_ps),
      .w_asid_i (w_asid), .w_g_i (w_g),
      .w_ppn0_i (w_ppn0), .w_plv0_i (w_plv0), .w_mat0_i (w_mat0), .w_d0_i (w_d0), .w_v0_i (w_v0),
      .w_ppn1_i (w_ppn1), .w_plv1_i (w_plv1), .w_mat1_i (w_mat1), .w_d1_i (w_d1), .w_v1_i (w_v1),
      .s0_found_o (s0_found), .s0_ppn_o (s0_ppn), .s0_ps_o (s0_ps), .s0_plv_o (s0_plv),
      .s0_d_o (), .s0_v_o (s0_v),   // fetch has no dirty check
      .s1_found_o (s1_found), .s1_ppn_o (s1_ppn), .s1_ps_o (s1_ps), .s1_plv_o (s1_plv),
      .s1_d_o (s1_d), .s1_v_o (s1_v)
   );

endmodule

// File: tb.f
+incdir+rtl
rtl/mmu_csr_pkg.sv
rtl/mmu_tlb_pkg.sv
rtl/mmu_dmw_check.sv
rtl/mmu_tlb_array.sv
rtl/mmu_tlb_write_ctrl.sv
rtl/mmu_fetch_xlate.sv
rtl/mmu_ls_xlate.sv
rtl/mmu_top.sv
verification/mmu_tb.sv

// File: verification/mmu_tb.sv
// inputs change on falling edges and outputs are checked 3 ns later; pa is checked only when defined
`timescale 1ns/1ps
`include "mmu_params.svh"

module mmu_tb;

   localparam int WATCHDOG_NS = 100000;

   logic                 clk;
   logic                 rst_n;
   logic [31:0]          fetch_va;
   logic [31:0]          data_va;
   mmu_csr_pkg::mem_op_e mem_op;
   mmu_csr_pkg::tlb_op_e tlb_op;
   logic                 csr_da;
   mmu_csr_pkg::plv_t    csr_plv;
   logic [9:0]           csr_asid;
   logic [31:0]          csr_tlbidx;
   logic [31:0]          csr_tlbehi;
   logic [31:0]          csr_tlbelo0;
   logic [31:0]          csr_tlbelo1;
   logic [31:0]          csr_dmw0;
   logic [31:0]          csr_dmw1;
   logic [31:0]          fetch_pa;
   logic [31:0]          data_pa;
   mmu_tlb_pkg::exc_e    fetch_exc;
   mmu_tlb_pkg::exc_e    data_exc;

   // reference TLB
   logic        m_e    [16];
   logic        m_4m   [16];
   logic [18:0] m_vppn [16];
   logic [9:0]  m_asid [16];
   logic        m_g    [16];
   logic [19:0] m_ppn  [16][2];
   logic [1:0]  m_plv  [16][2];
   logic        m_d    [16][2];
   logic        m_v    [16][2];
   int          m_fill;

   int checks;
   int errors;
   int test_no;
   int base_checks;
   int base_errors;

   logic [18:0] vppn_pool [6] = '{19'h12345, 19'h0a3c1, 19'h7f002,
                                  19'h40155, 19'h2b2aa, 19'h5d0f7};
   logic [9:0]  asid_pool [3] = '{10'h011, 10'h022, 10'h3c5};

   mmu_top DUT (
      .clk (clk), .rst_n (rst_n), .fetch_va_i (fetch_va), .data_va_i (data_va),
      .mem_op_i (mem_op), .tlb_op_i (tlb_op), .csr_da_i (csr_da), .csr_plv_i (csr_plv),
      .csr_asid_i (csr_asid), .csr_tlbidx_i (csr_tlbidx), .csr_tlbehi_i (csr_tlbehi),
      .csr_tlbelo0_i (csr_tlbelo0), .csr_tlbelo1_i (csr_tlbelo1),
      .csr_dmw0_i (csr_dmw0), .csr_dmw1_i (csr_dmw1),
      .fetch_pa_o (fetch_pa), .fetch_exc_o (fetch_exc),
      .data_pa_o (data_pa), .data_exc_o (data_exc)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
      $display("Testbench failed");
      $finish;
   end

   function automatic logic win_hit(input logic [31:0] dmw, input logic [31:0] va);
      logic priv;
      priv = (csr_plv == 2'd0 && dmw[`MMU_DMW_PLV0]) || (csr_plv == 2'd3 && dmw[`MMU_DMW_PLV3]);
      return priv && (dmw[`MMU_DMW_VSEG] == va[31:29]);
   endfunction

   function automatic logic entry_hits(input int i, input logic [31:0] va);
      logic vmatch;
      vmatch = m_4m[i] ? (m_vppn[i][18:9] == va[31:22]) : (m_vppn[i] == va[31:13]);
      return m_e[i] && (m_g[i] || m_asid[i] == csr_asid) && vmatch;
   endfunction

   // expected pa and code for one port; pa_ok clear where pa is undefined
   function automatic void model_xlate(input logic [31:0] va, input logic is_fetch,
                                       input mmu_csr_pkg::mem_op_e op, output logic [31:0] pa,
                                       output mmu_tlb_pkg::exc_e exc, output logic pa_ok);
      int   hit;
      logic h;
      pa    = va;
      exc   = mmu_tlb_pkg::exc_none;
      pa_ok = 1'b1;
      if (csr_da) return;
      if (win_hit(csr_dmw0, va)) begin
         pa = {csr_dmw0[`MMU_DMW_PSEG], va[28:0]};
         return;
      end
      if (win_hit(csr_dmw1, va)) begin
         pa = {csr_dmw1[`MMU_DMW_PSEG], va[28:0]};
         return;
      end
      hit = -1;
      for (int i = 0; i < 16; i++) begin
         if (hit < 0 && entry_hits(i, va)) hit = i;
      end
      h     = 1'b0;
      pa_ok = (hit >= 0);
      if (hit >= 0) begin
         h  = m_4m[hit] ? va[21] : va[12];
         pa = m_4m[hit] ? {m_ppn[hit][h][19:9], va[20:0]} : {m_ppn[hit][h], va[11:0]};
      end
      if (!is_fetch && op == mmu_csr_pkg::mem_none) return;
      pa_ok = 1'b0;
      if (csr_plv == 2'd3 && va[31]) exc = mmu_tlb_pkg::exc_ade;
      else if (hit < 0) exc = mmu_tlb_pkg::exc_tlbr;
      else if (!m_v[hit][h])
         exc = is_fetch ? mmu_tlb_pkg::exc_pif
             : (op == mmu_csr_pkg::mem_store ? mmu_tlb_pkg::exc_pis : mmu_tlb_pkg::exc_pil);
      else if (csr_plv > m_plv[hit][h]) exc = mmu_tlb_pkg::exc_ppi;
      else if (!is_fetch && op == mmu_csr_pkg::mem_store && !m_d[hit][h])
         exc = mmu_tlb_pkg::exc_pme;
      else pa_ok = 1'b1;
   endfunction

   task automatic set_half(input int idx, input int h, input logic [31:0] elo);
      m_ppn[idx][h] = elo[`MMU_TLBELO_PPN];
      m_plv[idx][h] = elo[`MMU_TLBELO_PLV];
      m_d[idx][h]   = elo[`MMU_TLBELO_D];
      m_v[idx][h]   = elo[`MMU_TLBELO_V];
   endtask

   task automatic model_write();
      int idx;
      if (tlb_op == mmu_csr_pkg::tlb_op_fill) begin
         idx    = m_fill;
         m_fill = (m_fill + 1) % 16;
      end else begin
         idx = int'(csr_tlbidx[`MMU_TLBIDX_INDEX]);
      end
      m_e[idx]    = !csr_tlbidx[`MMU_TLBIDX_NE];
      m_4m[idx]   = (csr_tlbidx[`MMU_TLBIDX_PS] == 6'd21);
      m_vppn[idx] = csr_tlbehi[`MMU_TLBEHI_VPPN];
      m_asid[idx] = csr_asid;
      m_g[idx]    = csr_tlbelo0[`MMU_TLBELO_G] & csr_tlbelo1[`MMU_TLBELO_G];
      set_half(idx, 0, csr_tlbelo0);
      set_half(idx, 1, csr_tlbelo1);
   endtask

   task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("ERR t=%0t %s exp=0x%08h got=0x%08h", $time, name, exp, got);
      end
   endtask

   task automatic check_ports();
      logic [31:0]       pa;
      mmu_tlb_pkg::exc_e exc;
      logic              pa_ok;
      model_xlate(fetch_va, 1'b1, mmu_csr_pkg::mem_none, pa, exc, pa_ok);
      check_val("fetch_exc_o", 32'(exc), 32'(fetch_exc));
      if (pa_ok) check_val("fetch_pa_o", pa, fetch_pa);
      model_xlate(data_va, 1'b0, mem_op, pa, exc, pa_ok);
      check_val("data_exc_o", 32'(exc), 32'(data_exc));
      if (pa_ok) check_val("data_pa_o", pa, data_pa);
   endtask

   // check, let the edge apply any write, return on the next falling edge
   task automatic tick();
      #3;
      check_ports();
      @(posedge clk);
      if (tlb_op != mmu_csr_pkg::tlb_op_none) model_write();
      @(negedge clk);
      tlb_op = mmu_csr_pkg::tlb_op_none;
   endtask

   function automatic logic [31:0] rand_va();
      logic [18:0] vppn;
      vppn = vppn_pool[$urandom_range(5)];
      if ($urandom_range(1) == 1) vppn[8:0] = 9'($urandom);   // other 4K page, same 4M region
      return {vppn, 13'($urandom)};
   endfunction

   function automatic logic [31:0] make_elo(input logic g);
      return {4'd0, 20'($urandom), 1'b0, g, 2'($urandom), 2'($urandom),
              1'($urandom), ($urandom_range(3) != 0)};
   endfunction

   function automatic logic [31:0] rand_dmw(input logic [31:0] va);
      logic [31:0] dmw;
      dmw                = '0;
      dmw[`MMU_DMW_VSEG] = ($urandom_range(1) == 1) ? va[31:29] : 3'($urandom);
      dmw[`MMU_DMW_PSEG] = 3'($urandom);
      dmw[`MMU_DMW_MAT]  = 2'($urandom);
      dmw[`MMU_DMW_PLV0] = 1'($urandom);
      dmw[`MMU_DMW_PLV3] = 1'($urandom);
      return dmw;
   endfunction

   // plv_mode 0 kernel only, 1 kernel or user, 2 any level
   task automatic rand_access(input int plv_mode);
      fetch_va = rand_va();
      data_va  = rand_va();
      csr_asid = asid_pool[$urandom_range(2)];
      case ($urandom_range(2))
         0:       mem_op = mmu_csr_pkg::mem_none;
         1:       mem_op = mmu_csr_pkg::mem_load;
         default: mem_op = mmu_csr_pkg::mem_store;
      endcase
      if (plv_mode == 0) csr_plv = 2'd0;
      else if (plv_mode == 1) csr_plv = ($urandom_range(1) == 1) ? 2'd3 : 2'd0;
      else csr_plv = 2'($urandom);
   endtask

   task automatic set_rand_entry(input logic [3:0] idx, input logic ne);
      logic is_4m;
      logic g_both;
      is_4m       = 1'($urandom);
      g_both      = ($urandom_range(2) == 0);
      csr_asid    = asid_pool[$urandom_range(2)];
      csr_tlbidx  = {ne, 1'b0, is_4m ? 6'd21 : 6'd12, 20'd0, idx};
      csr_tlbehi  = {vppn_pool[$urandom_range(5)], 13'($urandom)};
      csr_tlbelo0 = make_elo(g_both | 1'($urandom));
      csr_tlbelo1 = make_elo(g_both | 1'($urandom));
   endtask

   task automatic run_lookups(input int n, input int plv_mode, input int wr_pct);
      repeat (n) begin
         rand_access(plv_mode);
         if ($urandom_range(99) < wr_pct) begin
            set_rand_entry(4'($urandom), ($urandom_range(7) == 0));
            tlb_op = mmu_csr_pkg::tlb_op_wr;
         end
         tick();
      end
   endtask

   task automatic write_all(input logic ne);
      for (int i = 0; i < 16; i++) begin
         rand_access(1);
         set_rand_entry(4'(i), ne);
         tlb_op = mmu_csr_pkg::tlb_op_wr;
         tick();
      end
   endtask

   task automatic start_test();
      test_no++;
      base_checks = checks;
      base_errors = errors;
   endtask

   task automatic end_test(input string name);
      $display("test %0d %s: %0d checks, %0d errors", test_no, name,
               checks - base_checks, errors - base_errors);
   endtask

   task automatic wait_outputs_known();
      int n;
      n = 0;
      while (($isunknown(fetch_exc) || $isunknown(data_exc)) && n < 20) begin
         @(negedge clk);
         n++;
      end
      assert (!$isunknown(fetch_exc) && !$isunknown(data_exc)) else begin
         errors++;
         $display("exception outputs still unknown 20 cycles after reset release");
      end
   endtask

   function automatic logic [18:0] fill_vppn(input int k);
      return {3'b011, 16'(k * 977)};   // segment 3 is outside the pool
   endfunction

   initial begin
      void'($urandom(93914));
      rst_n       = 1'b0;
      fetch_va    = '0;
      data_va     = '0;
      mem_op      = mmu_csr_pkg::mem_none;
      tlb_op      = mmu_csr_pkg::tlb_op_none;
      csr_da      = 1'b0;
      csr_plv     = 2'd0;
      csr_asid    = '0;
      csr_tlbidx  = '0;
      csr_tlbehi  = '0;
      csr_tlbelo0 = '0;
      csr_tlbelo1 = '0;
      csr_dmw0    = '0;
      csr_dmw1    = '0;
      checks      = 0;
      errors      = 0;
      test_no     = 0;
      m_fill      = 0;
      for (int i = 0; i < 16; i++) m_e[i] = 1'b0;
      repeat (16) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      wait_outputs_known();

      start_test();
      repeat (20) begin
         rand_access(0);
         mem_op = mmu_csr_pkg::mem_load;   // empty TLB, so every mapped access misses
         tick();
      end
      csr_da = 1'b1;
      run_lookups(20, 2, 0);
      csr_da = 1'b0;
      end_test("reset miss and direct mode");

      start_test();
      repeat (60) begin
         rand_access(2);
         csr_dmw0 = rand_dmw(($urandom_range(1) == 1) ? fetch_va : data_va);
         csr_dmw1 = rand_dmw(($urandom_range(1) == 1) ? fetch_va : data_va);
         tick();
      end
      csr_dmw0 = '0;
      csr_dmw1 = '0;
      end_test("direct-mapped windows");

      start_test();
      write_all(1'b0);
      run_lookups(80, 1, 25);
      write_all(1'b1);
      run_lookups(10, 1, 0);
      end_test("tlbwr lookups and ne");

      start_test();
      write_all(1'b0);
      run_lookups(100, 2, 10);
      end_test("fetch exceptions");

      start_test();
      write_all(1'b0);
      run_lookups(100, 2, 10);
      end_test("load/store exceptions");

      start_test();
      csr_plv = 2'd0;
      for (int k = 0; k < 20; k++) begin
         csr_tlbidx  = {1'b0, 1'b0, 6'd12, 20'd0, 4'($urandom)};   // index ignored by fill
         csr_tlbehi  = {fill_vppn(k), 13'd0};
         csr_tlbelo0 = {4'd0, 20'h80000 | 20'(k), 8'b0100_1111};
         csr_tlbelo1 = {4'd0, 20'h90000 | 20'(k), 8'b0100_1111};
         tlb_op      = mmu_csr_pkg::tlb_op_fill;
         tick();
         if (k % 5 == 2) begin
            set_rand_entry(4'($urandom), 1'b0);
            tlb_op = mmu_csr_pkg::tlb_op_wr;
            tick();
         end
      end
      for (int k = 0; k < 20; k++) begin
         rand_access(0);
         fetch_va = {fill_vppn(k), 13'($urandom)};
         data_va  = {fill_vppn(k), 13'($urandom)};
         mem_op   = mmu_csr_pkg::mem_load;
         tick();
      end
      end_test("tlbfill order");

      $display("total: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule
